/* stepper_pkg.sv */
`default_nettype none

package stepper_pkg;

  typedef logic [7:0] phase_t;       // One coil period is 256 microsteps
  typedef logic [9:0] off_time_t;    // Off time in clock cycles
  typedef logic [7:0] short_time_t;  // Blank and minimum-on times
  typedef logic [2:0] cfg_addr_t;

  // Register map of the settings block
  localparam cfg_addr_t CFG_ADDR_THRESHOLD  = 3'd0;
  localparam cfg_addr_t CFG_ADDR_OFF_TIME   = 3'd1;
  localparam cfg_addr_t CFG_ADDR_BLANK_TIME = 3'd2;
  localparam cfg_addr_t CFG_ADDR_MIN_ON     = 3'd3;
  localparam cfg_addr_t CFG_ADDR_INV_HIGH   = 3'd4;
  localparam cfg_addr_t CFG_ADDR_INV_LOW    = 3'd5;

  typedef struct packed {
    off_time_t   fastdecay_threshold;  // Zero turns fast decay off
    off_time_t   off_time;
    short_time_t blank_time;
    short_time_t min_on_time;
    logic        invert_highside;
    logic        invert_lowside;
  } cfg_t;

  // Current count of each chopper timer of one coil
  typedef struct packed {
    short_time_t blank;
    short_time_t min_on;
    off_time_t   off;
  } timer_state_t;

  typedef enum logic [1:0] {
    decay_drive,
    decay_fast,
    decay_slow
  } decay_t;

endpackage

`default_nettype wire

/* stepper_config.sv */
`timescale 1ns/1ns
`default_nettype none

module stepper_config import stepper_pkg::*; #(
  parameter int CFG_DATA_WIDTH = 16
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cfg_write,
  input  cfg_addr_t                 cfg_addr,
  input  logic [CFG_DATA_WIDTH-1:0] cfg_wdata,
  output cfg_t                      cfg
);

  localparam int OFF_W   = $bits(off_time_t);
  localparam int SHORT_W = $bits(short_time_t);

  localparam cfg_t CFG_RESET = '{
    fastdecay_threshold: off_time_t'(0),
    off_time:            off_time_t'(40),
    blank_time:          short_time_t'(4),
    min_on_time:         short_time_t'(8),
    invert_highside:     1'b0,
    invert_lowside:      1'b0
  };

  // One field per strobe, the new value is seen the next cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg <= CFG_RESET;
    end else if (cfg_write) begin
      case (cfg_addr)
        CFG_ADDR_THRESHOLD: begin
          cfg.fastdecay_threshold <= cfg_wdata[OFF_W-1:0];
        end
        CFG_ADDR_OFF_TIME: begin
          cfg.off_time <= cfg_wdata[OFF_W-1:0];
        end
        CFG_ADDR_BLANK_TIME: begin
          cfg.blank_time <= cfg_wdata[SHORT_W-1:0];
        end
        CFG_ADDR_MIN_ON: begin
          cfg.min_on_time <= cfg_wdata[SHORT_W-1:0];
        end
        CFG_ADDR_INV_HIGH: begin
          cfg.invert_highside <= cfg_wdata[0];
        end
        CFG_ADDR_INV_LOW: begin
          cfg.invert_lowside <= cfg_wdata[0];
        end
        default: begin
          // Addresses 6 and 7 are not mapped
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* step_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module step_sequencer import stepper_pkg::*; #(
  parameter int STEP_SYNC = 1
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       step,
  input  logic       dir,
  input  logic       enable,
  output phase_t     phase_ct,
  output logic [3:0] pol
);

  logic       step_s;
  logic       dir_s;
  logic       step_d;
  logic       step_rise;
  logic [1:0] quad;
  logic       coil_a_pos;
  logic       coil_a_neg;
  logic       coil_b_pos;
  logic       coil_b_neg;

  generate
    if (STEP_SYNC != 0) begin : g_sync
      logic [1:0] step_ff;
      logic [1:0] dir_ff;

      always_ff @(posedge clk) begin
        if (reset) begin
          step_ff <= 2'b00;
          dir_ff  <= 2'b00;
        end else begin
          step_ff <= {step_ff[0], step};
          dir_ff  <= {dir_ff[0], dir};
        end
      end

      assign step_s = step_ff[1];
      assign dir_s  = dir_ff[1];  // Delayed with step so the two stay aligned
    end else begin : g_direct
      assign step_s = step;
      assign dir_s  = dir;
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (reset) begin
      step_d <= 1'b0;
    end else begin
      step_d <= step_s;
    end
  end

  assign step_rise = step_s & ~step_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase_ct <= '0;
    end else if (step_rise && enable) begin
      phase_ct <= dir_s ? phase_ct + 1'b1 : phase_ct - 1'b1;
    end
  end

  // Coil A is positive in quadrants 0 and 3, coil B in quadrants 0 and 1
  assign quad       = phase_ct[7:6];
  assign coil_a_pos = (quad == 2'd0) || (quad == 2'd3);
  assign coil_a_neg = (quad == 2'd1) || (quad == 2'd2);
  assign coil_b_pos = !quad[1];
  assign coil_b_neg = (quad == 2'd2) || (quad == 2'd3);

  always_ff @(posedge clk) begin
    if (reset) begin
      pol <= 4'b0101;  // Matches phase 0
    end else begin
      pol <= {coil_b_neg, coil_b_pos, coil_a_neg, coil_a_pos};
    end
  end

  a_pol_complement: assert property (@(posedge clk) disable iff (reset)
    (pol[0] != pol[1]) && (pol[2] != pol[3]))
    else $error("coil polarity bits are not complementary: %b", pol);

endmodule

`default_nettype wire

/* chopper_timers.sv */
`timescale 1ns/1ns
`default_nettype none

module chopper_timers import stepper_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  cfg_t         cfg,
  input  logic         starting,
  input  logic         offtimer_en,
  output timer_state_t timers
);

  logic blank_run;
  logic min_on_run;
  logic off_run;

  assign blank_run  = timers.blank != '0;
  assign min_on_run = timers.min_on != '0;
  assign off_run    = timers.off != '0;

  // Blank and minimum-on both restart at a bridge turnover
  always_ff @(posedge clk) begin
    if (reset) begin
      timers.blank  <= '0;
      timers.min_on <= '0;
    end else if (starting) begin
      timers.blank  <= cfg.blank_time;
      timers.min_on <= cfg.min_on_time;
    end else begin
      if (blank_run) begin
        timers.blank <= timers.blank - 1'b1;
      end
      if (min_on_run) begin
        timers.min_on <= timers.min_on - 1'b1;
      end
    end
  end

  // The off timer holds the bridge in decay after a comparator trip
  always_ff @(posedge clk) begin
    if (reset) begin
      timers.off <= '0;
    end else if (offtimer_en) begin
      timers.off <= cfg.off_time;
    end else if (off_run) begin
      timers.off <= timers.off - 1'b1;
    end
  end

  // The trigger comes from the bridge, which must respect the blank window
  a_no_trip_in_blank: assert property (@(posedge clk) disable iff (reset)
    offtimer_en |-> !blank_run)
    else $error("off timer loaded while blank timer is %0d", timers.blank);

endmodule

`default_nettype wire

/* bridge_control.sv */
`timescale 1ns/1ns
`default_nettype none

module bridge_control import stepper_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         enable,
  input  cfg_t         cfg,
  input  logic [3:0]   pol,
  input  logic [1:0]   analog_cmp,
  input  timer_state_t timers_a,
  input  timer_state_t timers_b,
  output logic [1:0]   starting,
  output logic [1:0]   offtimer_en,
  output logic [3:0]   gate_h,
  output logic [3:0]   gate_l,
  output logic         fault
);

  logic [3:0]   pol_q;   // First shift stage, the polarity the gates use
  logic [3:0]   pol_qq;  // Second stage, one cycle older
  timer_state_t tm [2];
  decay_t       decay [2];
  logic [1:0]   coil_fault;
  logic         fault_next;
  logic [3:0]   h_on_next;
  logic [3:0]   l_on_next;
  logic [3:0]   h_on;
  logic [3:0]   l_on;

  // A zero threshold leaves only slow decay
  function automatic decay_t pick_decay(timer_state_t t, off_time_t threshold);
    if (t.off == '0) begin
      return decay_drive;
    end
    if (threshold != '0 && t.off >= threshold) begin
      return decay_fast;
    end
    return decay_slow;
  endfunction

  assign tm[0] = timers_a;
  assign tm[1] = timers_b;

  always_ff @(posedge clk) begin
    if (reset) begin
      pol_q  <= 4'b0101;
      pol_qq <= 4'b0101;
    end else begin
      pol_q  <= pol;
      pol_qq <= pol_q;
    end
  end

  assign starting[0] = pol_q[1:0] != pol_qq[1:0];
  assign starting[1] = pol_q[3:2] != pol_qq[3:2];

  always_comb begin
    for (int c = 0; c < 2; c++) begin
      decay[c]       = pick_decay(tm[c], cfg.fastdecay_threshold);
      offtimer_en[c] = analog_cmp[c] && tm[c].blank == '0 && tm[c].off == '0;
      coil_fault[c]  = tm[c].min_on != '0 && tm[c].off != '0;  // Tripped too early
    end
  end

  // Latched until the driver is disabled
  assign fault_next = enable && (fault || coil_fault != 2'b00);

  always_ff @(posedge clk) begin
    if (reset) begin
      fault <= 1'b0;
    end else begin
      fault <= fault_next;
    end
  end

  // Legs 0 and 1 belong to coil A, legs 2 and 3 to coil B
  always_comb begin
    for (int leg = 0; leg < 4; leg++) begin
      case (decay[leg >> 1])
        decay_fast: begin
          h_on_next[leg] = !pol_q[leg];
          l_on_next[leg] = pol_q[leg];
        end
        decay_slow: begin
          h_on_next[leg] = 1'b0;
          l_on_next[leg] = 1'b1;
        end
        default: begin
          h_on_next[leg] = pol_q[leg];
          l_on_next[leg] = !pol_q[leg];
        end
      endcase
      if (fault_next || !enable) begin
        h_on_next[leg] = 1'b0;
        l_on_next[leg] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      h_on <= 4'b0000;
      l_on <= 4'b0000;
    end else begin
      h_on <= h_on_next;
      l_on <= l_on_next;
    end
  end

  assign gate_h = h_on ^ {4{cfg.invert_highside}};
  assign gate_l = l_on ^ {4{cfg.invert_lowside}};

  // No leg has its high and low side on together
  a_no_shoot_through: assert property (@(posedge clk) disable iff (reset)
    (h_on & l_on) == 4'b0000)
    else $error("bridge leg with high and low side on: h=%b l=%b", h_on, l_on);

endmodule

`default_nettype wire

/* microstepper_top.sv */
`timescale 1ns/1ns
`default_nettype none

module microstepper_top import stepper_pkg::*; #(
  parameter int CFG_DATA_WIDTH = 16,
  parameter int STEP_SYNC      = 1
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      step,
  input  logic                      dir,
  input  logic                      enable,
  input  logic [1:0]                analog_cmp,  // Bit 0 is coil A
  input  logic                      cfg_write,
  input  cfg_addr_t                 cfg_addr,
  input  logic [CFG_DATA_WIDTH-1:0] cfg_wdata,
  output logic [3:0]                gate_h,      // Legs a1, a2, b1, b2
  output logic [3:0]                gate_l,
  output logic                      fault,
  output phase_t                    phase_ct
);

  cfg_t         cfg;
  logic [3:0]   pol;
  logic [1:0]   starting;
  logic [1:0]   offtimer_en;
  timer_state_t timers_a;
  timer_state_t timers_b;

  stepper_config #(
    .CFG_DATA_WIDTH(CFG_DATA_WIDTH)
  ) u_config (
    .clk      (clk),
    .reset    (reset),
    .cfg_write(cfg_write),
    .cfg_addr (cfg_addr),
    .cfg_wdata(cfg_wdata),
    .cfg      (cfg)
  );

  step_sequencer #(
    .STEP_SYNC(STEP_SYNC)
  ) u_sequencer (
    .clk     (clk),
    .reset   (reset),
    .step    (step),
    .dir     (dir),
    .enable  (enable),
    .phase_ct(phase_ct),
    .pol     (pol)
  );

  chopper_timers chop_a (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg),
    .starting   (starting[0]),
    .offtimer_en(offtimer_en[0]),
    .timers     (timers_a)
  );

  chopper_timers chop_b (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg),
    .starting   (starting[1]),
    .offtimer_en(offtimer_en[1]),
    .timers     (timers_b)
  );

  bridge_control u_bridge (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .cfg        (cfg),
    .pol        (pol),
    .analog_cmp (analog_cmp),
    .timers_a   (timers_a),
    .timers_b   (timers_b),
    .starting   (starting),
    .offtimer_en(offtimer_en),
    .gate_h     (gate_h),
    .gate_l     (gate_l),
    .fault      (fault)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Released just after a rising edge, like every other input
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #10 reset = 1'b0;
  end

endmodule

`default_nettype wire

/* microstepper_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module microstepper_tb import stepper_pkg::*; ();

  localparam int CFG_DATA_WIDTH = 16;
  localparam int STEP_TIMEOUT   = 8;
  localparam int SETTLE_TIMEOUT = 20;
  localparam int DECAY_LIMIT    = 2000;

  logic                      clk;
  logic                      reset;
  logic                      step;
  logic                      dir;
  logic                      enable;
  logic [1:0]                analog_cmp;
  logic                      cfg_write;
  cfg_addr_t                 cfg_addr;
  logic [CFG_DATA_WIDTH-1:0] cfg_wdata;
  logic [3:0]                gate_h;
  logic [3:0]                gate_l;
  logic                      fault;
  phase_t                    phase_ct;

  int     errors;
  int     test_start_errors;
  int     tests_run;
  int     tests_failed;
  string  cur_test;
  phase_t model_phase;  // Expected step phase
  logic   inv_h;
  logic   inv_l;
  int     off_time_m;
  int     threshold_m;
  int     blank_m;
  int     min_on_m;

  tb_clock_gen #(
    .PERIOD      (100),
    .RESET_CYCLES(10)
  ) u_clock (
    .clk  (clk),
    .reset(reset)
  );

  microstepper_top #(
    .CFG_DATA_WIDTH(CFG_DATA_WIDTH),
    .STEP_SYNC     (1)
  ) DUT (
    .clk       (clk),
    .reset     (reset),
    .step      (step),
    .dir       (dir),
    .enable    (enable),
    .analog_cmp(analog_cmp),
    .cfg_write (cfg_write),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .gate_h    (gate_h),
    .gate_l    (gate_l),
    .fault     (fault),
    .phase_ct  (phase_ct)
  );

  function automatic logic coil_a_pos(phase_t p);
    return p[7:6] == 2'd0 || p[7:6] == 2'd3;
  endfunction

  function automatic logic coil_b_pos(phase_t p);
    return p[7:6] == 2'd0 || p[7:6] == 2'd1;
  endfunction

  // Returns {h[1:0], l[1:0]} of one coil, index 0 being the first leg of the coil
  function automatic logic [3:0] coil_on(logic pos, decay_t mode);
    logic [1:0] drive_h;
    drive_h = pos ? 2'b01 : 2'b10;
    case (mode)
      decay_fast: return {~drive_h, drive_h};
      decay_slow: return {2'b00, 2'b11};
      default:    return {drive_h, ~drive_h};
    endcase
  endfunction

  function automatic logic [7:0] expected_gates(decay_t mode_a, decay_t mode_b, logic all_off);
    logic [3:0] a;
    logic [3:0] b;
    logic [3:0] h;
    logic [3:0] l;
    a = coil_on(coil_a_pos(model_phase), mode_a);
    b = coil_on(coil_b_pos(model_phase), mode_b);
    h = {b[3:2], a[3:2]};
    l = {b[1:0], a[1:0]};
    if (all_off) begin
      h = 4'b0000;
      l = 4'b0000;
    end
    return {h ^ {4{inv_h}}, l ^ {4{inv_l}}};  // Pins as {gate_h, gate_l}
  endfunction

  task automatic tick();
    @(posedge clk);
    #10;
  endtask

  task automatic idle(int cycles);
    repeat (cycles) tick();
  endtask

  task automatic check_value(string what, int expected, int actual);
    assert (expected == actual) else begin
      $display("MISMATCH %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_true(logic cond, string text);
    assert (cond) else begin
      $display("%s: %s", cur_test, text);
      errors++;
    end
  endtask

  task automatic wait_gates(logic [7:0] pattern, int limit);
    int n;
    n = 0;
    while ({gate_h, gate_l} != pattern && n < limit) begin
      tick();
      n++;
    end
    check_true({gate_h, gate_l} == pattern,
      $sformatf("gates never reached %h within %0d cycles", pattern, limit));
  endtask

  task automatic wait_gates_leave(logic [7:0] pattern, int limit);
    int n;
    n = 0;
    while ({gate_h, gate_l} == pattern && n < limit) begin
      tick();
      n++;
    end
    check_true({gate_h, gate_l} != pattern,
      $sformatf("gates stayed at %h for %0d cycles", pattern, limit));
  endtask

  // Counts the cycles for which the gates hold one pattern
  task automatic count_gates(logic [7:0] pattern, int limit, output int n);
    n = 0;
    while ({gate_h, gate_l} == pattern && n < limit) begin
      tick();
      n++;
    end
    check_true(n < limit, "gates never left the decay state");
  endtask

  task automatic wait_phase(int limit);
    int n;
    n = 0;
    while (phase_ct != model_phase && n < limit) begin
      tick();
      n++;
    end
    check_true(phase_ct == model_phase, "phase counter did not follow the step pulse");
  endtask

  task automatic wait_fault(logic level, int limit);
    int n;
    n = 0;
    while (fault != level && n < limit) begin
      tick();
      n++;
    end
    check_true(fault == level, $sformatf("fault did not go to %0b", level));
  endtask

  task automatic step_once(logic up);
    dir  = up;
    step = 1'b1;
    idle(2);
    step = 1'b0;
    idle(2);
    model_phase = up ? model_phase + 8'd1 : model_phase - 8'd1;
    wait_phase(STEP_TIMEOUT);
  endtask

  // Steps until coil A changes polarity, which gives a bridge turnover
  task automatic cross_coil_a_edge(logic up);
    logic start_pos;
    int   n;
    start_pos = coil_a_pos(model_phase);
    n = 0;
    while (coil_a_pos(model_phase) == start_pos && n < 70) begin
      step_once(up);
      n++;
    end
    check_true(coil_a_pos(model_phase) != start_pos, "coil A never changed polarity");
  endtask

  task automatic write_cfg(cfg_addr_t addr, int data);
    cfg_write = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = CFG_DATA_WIDTH'(data);
    tick();
    cfg_write = 1'b0;
    case (addr)
      CFG_ADDR_THRESHOLD:  threshold_m = data;
      CFG_ADDR_OFF_TIME:   off_time_m = data;
      CFG_ADDR_BLANK_TIME: blank_m = data;
      CFG_ADDR_MIN_ON:     min_on_m = data;
      CFG_ADDR_INV_HIGH:   inv_h = data[0];
      CFG_ADDR_INV_LOW:    inv_l = data[0];
      default: ;
    endcase
  endtask

  task automatic pulse_cmp(logic [1:0] coils);
    analog_cmp = coils;
    tick();
    analog_cmp = 2'b00;
  endtask

  task automatic begin_test(string name);
    cur_test = name;
    test_start_errors = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors > test_start_errors) begin
      tests_failed++;
      $display("%s: failed with %0d errors", cur_test, errors - test_start_errors);
    end else begin
      $display("%s: ok", cur_test);
    end
  endtask

  task automatic test_reset_state();
    int n;
    begin_test("reset_state");
    n = 0;
    tick();
    while (reset && n < 20) begin
      tick();
      n++;
    end
    check_true(!reset, "reset was never released");
    wait_gates(expected_gates(decay_drive, decay_drive, 1'b0), SETTLE_TIMEOUT);
    check_value("gates", 8'b0101_1010, {gate_h, gate_l});  // Both coils positive
    check_value("phase_ct", 0, phase_ct);
    check_value("fault", 0, fault);
    end_test();
  endtask

  task automatic test_random_steps();
    int         bursts;
    int         count;
    logic       up;
    logic [1:0] quad_before;
    begin_test("random_steps");
    bursts = 4 + int'($urandom % 3);
    repeat (bursts) begin
      up    = 1'($urandom % 2);
      count = 1 + int'($urandom % 90);
      repeat (count) begin
        quad_before = model_phase[7:6];
        step_once(up);
        check_value("phase_ct", model_phase, phase_ct);
        if (model_phase[7:6] != quad_before) begin
          wait_gates(expected_gates(decay_drive, decay_drive, 1'b0), SETTLE_TIMEOUT);
        end
      end
    end
    end_test();
  endtask

  task automatic test_chop_decay();
    logic [7:0] drive;
    logic [7:0] fast;
    logic [7:0] slow;
    int         n;
    begin_test("chop_decay");
    write_cfg(CFG_ADDR_THRESHOLD, 20);
    cross_coil_a_edge(1'b1);
    drive = expected_gates(decay_drive, decay_drive, 1'b0);
    fast  = expected_gates(decay_fast, decay_drive, 1'b0);
    slow  = expected_gates(decay_slow, decay_drive, 1'b0);
    wait_gates(drive, SETTLE_TIMEOUT);
    idle(blank_m + min_on_m + 4);  // Past the blank and minimum-on windows
    pulse_cmp(2'b01);
    wait_gates_leave(drive, SETTLE_TIMEOUT);
    check_value("first decay gates", fast, {gate_h, gate_l});
    count_gates(fast, DECAY_LIMIT, n);
    check_value("fast decay cycles", off_time_m - threshold_m + 1, n);
    check_value("slow decay gates", slow, {gate_h, gate_l});
    count_gates(slow, DECAY_LIMIT, n);
    check_value("slow decay cycles", threshold_m - 1, n);
    check_value("gates after decay", drive, {gate_h, gate_l});
    check_value("fault", 0, fault);
    end_test();
  endtask

  task automatic test_early_trip_fault();
    logic [7:0] drive;
    logic [7:0] off_pins;
    begin_test("early_trip_fault");
    write_cfg(CFG_ADDR_MIN_ON, 30);
    cross_coil_a_edge(1'b0);
    drive    = expected_gates(decay_drive, decay_drive, 1'b0);
    off_pins = expected_gates(decay_drive, decay_drive, 1'b1);
    wait_gates(drive, SETTLE_TIMEOUT);
    idle(blank_m + 2);  // Blank is over, minimum-on still running
    pulse_cmp(2'b01);
    wait_fault(1'b1, SETTLE_TIMEOUT);
    // Held well past the end of both timers, so only the latch keeps it set
    repeat (off_time_m + min_on_m + 8) begin
      check_value("gates during fault", off_pins, {gate_h, gate_l});
      check_value("fault held", 1, fault);
      tick();
    end
    enable = 1'b0;
    wait_fault(1'b0, SETTLE_TIMEOUT);
    enable = 1'b1;
    wait_gates(drive, SETTLE_TIMEOUT);
    check_value("fault after enable", 0, fault);
    write_cfg(CFG_ADDR_MIN_ON, 8);
    end_test();
  endtask

  task automatic test_invert_slow_only();
    logic [7:0] drive;
    logic [7:0] slow;
    int         n;
    begin_test("invert_slow_only");
    write_cfg(CFG_ADDR_INV_HIGH, 1);
    write_cfg(CFG_ADDR_INV_LOW, 1);
    drive = expected_gates(decay_drive, decay_drive, 1'b0);
    slow  = expected_gates(decay_slow, decay_drive, 1'b0);
    wait_gates(drive, SETTLE_TIMEOUT);
    write_cfg(CFG_ADDR_THRESHOLD, 0);
    pulse_cmp(2'b01);
    wait_gates_leave(drive, SETTLE_TIMEOUT);
    check_value("first decay gates", slow, {gate_h, gate_l});
    count_gates(slow, DECAY_LIMIT, n);
    check_value("slow decay cycles", off_time_m, n);
    check_value("gates after decay", drive, {gate_h, gate_l});
    end_test();
  endtask

  initial begin
    void'($urandom(68019));
    step        = 1'b0;
    dir         = 1'b0;
    enable      = 1'b1;
    analog_cmp  = 2'b00;
    cfg_write   = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    errors      = 0;
    tests_run   = 0;
    tests_failed = 0;
    model_phase = '0;
    inv_h       = 1'b0;
    inv_l       = 1'b0;
    off_time_m  = 40;  // Register reset values
    threshold_m = 0;
    blank_m     = 4;
    min_on_m    = 8;

    test_reset_state();
    test_random_steps();
    test_chop_decay();
    test_early_trip_fault();
    test_invert_slow_only();

    $display("summary: %0d tests, %0d failing, %0d failed checks",
      tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
stepper_pkg.sv
stepper_config.sv
step_sequencer.sv
chopper_timers.sv
bridge_control.sv
microstepper_top.sv
tb_clock_gen.sv
microstepper_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = microstepper_tb
FILELIST  = verilog.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
